// File: sources.f
common/p4_router_pkg.sv
src/p4_router_regs.sv
ingress/ing_route_stage.sv
ingress/ing_ports.sv
src/egr_switch.sv
src/p4_router.sv
dv/p4_router_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= p4_router_tb
FLAGS     ?= --binary --timing
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLAGS OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sources.f
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/p4_router_tb.sv
`timescale 1ns/1ns
`default_nettype none

module p4_router_tb import p4_router_pkg::*; ();

    localparam int num_pairs   = num_ing_ports * num_egr_ports;
    localparam int n_fwd       = 100;
    localparam int n_cont      = 30;
    localparam int n_bp        = 100;
    localparam int n_drop      = 40;
    localparam int n_chg       = 40;
    localparam int total_pkts  = num_ing_ports * (n_fwd + n_cont + n_bp + n_drop + n_chg);
    localparam int wd_cycles   = total_pkts * 200 + 1000;
    localparam dest_addr_t chg_addr = 3'd5;

    logic                             clk;
    logic                             rst_n;
    logic         [num_ing_ports-1:0] ing_valid;
    stream_beat_t [num_ing_ports-1:0] ing_beat;
    logic         [num_ing_ports-1:0] ing_ready;
    logic         [num_egr_ports-1:0] egr_valid;
    stream_beat_t [num_egr_ports-1:0] egr_beat;
    logic         [num_egr_ports-1:0] egr_ready;
    logic                             cfg_req;
    logic                             cfg_we;
    cfg_addr_t                        cfg_addr;
    cfg_data_t                        cfg_wdata;
    cfg_data_t                        cfg_rdata;
    logic                             cfg_ack;

    // Model state
    logic [15:0]  lfsr_state;
    route_entry_t model_tab [route_entries];
    drop_cnt_t    drop_exp [num_ing_ports];
    byte_t        seq [num_ing_ports];
    stream_beat_t exp_q [num_pairs][$];
    logic                     bp_mode;
    logic                     chg_busy;
    logic [num_ing_ports-1:0] hold_a;

    p4_router UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .ing_valid (ing_valid),
        .ing_beat  (ing_beat),
        .ing_ready (ing_ready),
        .egr_valid (egr_valid),
        .egr_beat  (egr_beat),
        .egr_ready (egr_ready),
        .cfg_req   (cfg_req),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg_ack   (cfg_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers

    // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r[i] = lfsr_state[0];
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_beat(input string name, input stream_beat_t got, input stream_beat_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run("egress beat mismatch");
        end
    endtask

    task automatic check_rdata(input string name, input cfg_data_t got, input cfg_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run("register read mismatch");
        end
    endtask

    task automatic check_drop(input string name, input drop_cnt_t got, input drop_cnt_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            fail_run("drop counter mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Config master and stream drivers

    task automatic cfg_access(input logic we, input cfg_addr_t addr, input cfg_data_t wdata,
                              output cfg_data_t rdata);
        @(negedge clk);
        cfg_req   = 1'b1;
        cfg_we    = we;
        cfg_addr  = addr;
        cfg_wdata = wdata;
        do @(negedge clk); while (!cfg_ack);
        rdata = cfg_rdata;
        // Model follows the table at the ack
        if (we && addr < reg_drop_base) begin
            model_tab[dest_addr_t'(addr)] = route_entry_t'(wdata[1:0]);
        end
        cfg_req = 1'b0;
        while (cfg_ack) begin
            @(negedge clk);
        end
    endtask

    // mode 0 all forward, 1 all to egress 0, 2 odd addresses forward
    task automatic load_table(input int mode);
        cfg_data_t rd;
        logic      fwd;
        logic      egr;
        for (int a = 0; a < route_entries; a++) begin
            fwd = (mode != 2) || (a % 2 == 1);
            egr = (mode == 1) ? 1'b0 : 1'(rand_bits(1));
            cfg_access(1'b1, cfg_addr_t'(a), {14'(rand_bits(14)), fwd, egr}, rd);
        end
    endtask

    task automatic drive_packets(input int ing, input int count);
        byte_t        b [8];
        stream_beat_t beat;
        dest_addr_t   dest;
        route_entry_t ent;
        int           len;
        for (int p = 0; p < count; p++) begin
            len  = 2 + int'(rand_bits(3)) % 7;
            dest = dest_addr_t'(rand_bits(3));
            // Keep away from the entry being rewritten
            while (chg_busy && dest == chg_addr) begin
                dest = dest_addr_t'(rand_bits(3));
            end
            hold_a[ing] = (dest == chg_addr);
            b[0] = byte_t'(dest);
            b[1] = byte_t'(ing);
            b[2] = seq[ing];
            for (int k = 3; k < 8; k++) begin
                b[k] = byte_t'(rand_bits(8));
            end
            seq[ing] = seq[ing] + 1'b1;
            for (int k = 0; k < len; k++) begin
                beat.data      = b[k];
                beat.last      = (k == len - 1);
                ing_valid[ing] = 1'b1;
                ing_beat[ing]  = beat;
                #1;
                while (!ing_ready[ing]) begin
                    @(negedge clk);
                    #1;
                end
                // Route fixed at the first beat
                if (k == 0) begin
                    ent = model_tab[dest];
                    if (ent.fwd) begin
                        for (int j = 0; j < len; j++) begin
                            beat.data = b[j];
                            beat.last = (j == len - 1);
                            exp_q[ing * num_egr_ports + int'(ent.egr)].push_back(beat);
                        end
                    end else begin
                        drop_exp[ing] = drop_exp[ing] + 1'b1;
                    end
                end
                @(negedge clk);
            end
            hold_a[ing]    = 1'b0;
            ing_valid[ing] = 1'b0;
            if (rand_bits(1) != 0) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic change_route();
        cfg_data_t rd;
        route_entry_t ent;
        repeat (50) @(negedge clk);
        chg_busy = 1'b1;
        @(negedge clk);
        while (hold_a != '0) begin
            @(negedge clk);
        end
        ent.fwd = 1'b1;
        ent.egr = ~model_tab[chg_addr].egr;
        cfg_access(1'b1, cfg_addr_t'(chg_addr), {14'(rand_bits(14)), ent}, rd);
        chg_busy = 1'b0;
    endtask

    function automatic int pending_beats();
        int n;
        n = 0;
        for (int i = 0; i < num_pairs; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    task automatic wait_drain();
        while (pending_beats() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic run_traffic(input int count);
        @(negedge clk);
        fork
            drive_packets(0, count);
            drive_packets(1, count);
        join
        wait_drain();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Egress monitors and ready

    task automatic watch_egress(input int e);
        stream_beat_t pkt [$];
        stream_beat_t exp;
        int           src;
        forever begin
            @(negedge clk);
            #1;
            if (egr_valid[e] && egr_ready[e]) begin
                pkt.push_back(egr_beat[e]);
                if (egr_beat[e].last) begin
                    if (pkt.size() < 2) begin
                        fail_run($sformatf("egress %0d sent a packet shorter than 2 beats", e));
                    end
                    src = int'(pkt[1].data);
                    if (src >= num_ing_ports) begin
                        fail_run($sformatf("egress %0d packet names unknown ingress %0d", e, src));
                    end
                    foreach (pkt[j]) begin
                        if (exp_q[src * num_egr_ports + e].size() == 0) begin
                            fail_run($sformatf("egress %0d got a packet not expected from %0d",
                                               e, src));
                        end
                        exp = exp_q[src * num_egr_ports + e].pop_front();
                        check_beat($sformatf("egr_beat[%0d]", e), pkt[j], exp);
                    end
                    pkt.delete();
                end
            end
        end
    endtask

    initial begin
        egr_ready = '1;
        forever begin
            @(negedge clk);
            for (int e = 0; e < num_egr_ports; e++) begin
                egr_ready[e] = bp_mode ? 1'(rand_bits(1)) : 1'b1;
            end
        end
    end

    initial begin
        fork
            watch_egress(0);
            watch_egress(1);
        join
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        fail_run("watchdog expired before all packets were checked");
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        cfg_data_t rd;
        rst_n      = 1'b0;
        ing_valid  = '0;
        ing_beat   = '0;
        cfg_req    = 1'b0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        bp_mode    = 1'b0;
        chg_busy   = 1'b0;
        hold_a     = '0;
        lfsr_state = 16'd50478;
        for (int i = 0; i < route_entries; i++) begin
            model_tab[i] = '0;
        end
        for (int i = 0; i < num_ing_ports; i++) begin
            drop_exp[i] = '0;
            seq[i]      = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (egr_valid !== '0 || cfg_ack !== 1'b0) begin
            fail_run("outputs were not idle after reset");
        end

        // Register readback with unmapped addresses reading zero
        load_table(0);
        for (int a = 0; a < 16; a++) begin
            cfg_access(1'b0, cfg_addr_t'(a), '0, rd);
            if (a < route_entries) begin
                check_rdata("cfg_rdata", rd, {14'd0, model_tab[a]});
            end else begin
                check_rdata("cfg_rdata", rd, '0);
            end
        end

        load_table(0);
        run_traffic(n_fwd);

        // Both ingresses contend for egress 0
        load_table(1);
        run_traffic(n_cont);

        bp_mode = 1'b1;
        load_table(0);
        run_traffic(n_bp);

        load_table(2);
        run_traffic(n_drop);
        for (int i = 0; i < num_ing_ports; i++) begin
            cfg_access(1'b0, cfg_addr_t'(int'(reg_drop_base) + i), '0, rd);
            check_drop("drop_cnt", drop_cnt_t'(rd), drop_exp[i]);
            cfg_access(1'b1, cfg_addr_t'(int'(reg_drop_base) + i), '0, rd);
            drop_exp[i] = '0;
            cfg_access(1'b0, cfg_addr_t'(int'(reg_drop_base) + i), '0, rd);
            check_drop("drop_cnt", drop_cnt_t'(rd), drop_exp[i]);
        end

        // Entry rewritten while traffic flows
        load_table(0);
        @(negedge clk);
        fork
            drive_packets(0, n_chg);
            drive_packets(1, n_chg);
            change_route();
        join
        wait_drain();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/p4_router.sv
`timescale 1ns/1ns
`default_nettype none

module p4_router import p4_router_pkg::*; (
    input  var logic                             clk,
    input  var logic                             rst_n,
    input  var logic         [num_ing_ports-1:0] ing_valid,
    input  var stream_beat_t [num_ing_ports-1:0] ing_beat,
    output logic             [num_ing_ports-1:0] ing_ready,
    output logic             [num_egr_ports-1:0] egr_valid,
    output stream_beat_t     [num_egr_ports-1:0] egr_beat,
    input  var logic         [num_egr_ports-1:0] egr_ready,
    input  var logic                             cfg_req,
    input  var logic                             cfg_we,
    input  var cfg_addr_t                        cfg_addr,
    input  var cfg_data_t                        cfg_wdata,
    output cfg_data_t                            cfg_rdata,
    output logic                                 cfg_ack
);

    route_table_t                     route_table;
    logic         [num_ing_ports-1:0] drop_pulse;
    logic         [num_ing_ports-1:0] sw_valid;
    tagged_beat_t [num_ing_ports-1:0] sw_beat;
    logic         [num_ing_ports-1:0] sw_ready;

    // Table and counters, beside the stages they steer
    p4_router_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_req     (cfg_req),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .cfg_ack     (cfg_ack),
        .drop_pulse  (drop_pulse),
        .route_table (route_table)
    );

    ing_ports u_ing (
        .clk         (clk),
        .rst_n       (rst_n),
        .ing_valid   (ing_valid),
        .ing_beat    (ing_beat),
        .ing_ready   (ing_ready),
        .route_table (route_table),
        .out_valid   (sw_valid),
        .out_beat    (sw_beat),
        .out_ready   (sw_ready),
        .drop_pulse  (drop_pulse)
    );

    egr_switch u_egr (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sw_valid),
        .in_beat   (sw_beat),
        .in_ready  (sw_ready),
        .egr_valid (egr_valid),
        .egr_beat  (egr_beat),
        .egr_ready (egr_ready)
    );

endmodule

`default_nettype wire

// File: src/egr_switch.sv
`timescale 1ns/1ns
`default_nettype none

module egr_switch import p4_router_pkg::*; (
    input  var logic                             clk,
    input  var logic                             rst_n,
    input  var logic         [num_ing_ports-1:0] in_valid,
    input  var tagged_beat_t [num_ing_ports-1:0] in_beat,
    output logic             [num_ing_ports-1:0] in_ready,
    output logic             [num_egr_ports-1:0] egr_valid,
    output stream_beat_t     [num_egr_ports-1:0] egr_beat,
    input  var logic         [num_egr_ports-1:0] egr_ready
);

    logic     [num_egr_ports-1:0] lock;
    // Last winner, also the round-robin pointer
    ing_idx_t                     owner    [num_egr_ports];
    ing_idx_t                     sel      [num_egr_ports];
    logic     [num_egr_ports-1:0] sel_ok;
    ing_idx_t                     cand;

    //////////////////////////////////////////////////////////////////////
    // Arbitration and forwarding

    always_comb begin
        in_ready = '0;
        cand     = '0;
        for (int e = 0; e < num_egr_ports; e++) begin
            // Locked egress keeps its owner
            sel[e]    = owner[e];
            sel_ok[e] = lock[e];
            if (!lock[e]) begin
                // Scan from the farthest candidate so the nearest one wins
                for (int k = num_ing_ports; k >= 1; k--) begin
                    cand = ing_idx_t'((int'(owner[e]) + k) % num_ing_ports);
                    if (in_valid[cand] && in_beat[cand].egr == egr_idx_t'(e)) begin
                        sel[e]    = cand;
                        sel_ok[e] = 1'b1;
                    end
                end
            end
            egr_valid[e] = sel_ok[e] && in_valid[sel[e]];
            egr_beat[e]  = in_beat[sel[e]].beat;

            // Ready goes back only to the granted ingress
            if (sel_ok[e] && egr_ready[e]) begin
                in_ready[sel[e]] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Packet lock

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock <= '0;
            for (int e = 0; e < num_egr_ports; e++) begin
                owner[e] <= '0;
            end
        end else begin
            for (int e = 0; e < num_egr_ports; e++) begin
                // Grant taken as soon as a beat is offered and held while stalled
                if (!lock[e] && sel_ok[e]) begin
                    lock[e]  <= 1'b1;
                    owner[e] <= sel[e];
                end
                // Release once the last beat has moved
                if (egr_valid[e] && egr_ready[e] && egr_beat[e].last) begin
                    lock[e] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: ingress/ing_ports.sv
`timescale 1ns/1ns
`default_nettype none

module ing_ports import p4_router_pkg::*; (
    input  var logic                             clk,
    input  var logic                             rst_n,
    input  var logic         [num_ing_ports-1:0] ing_valid,
    input  var stream_beat_t [num_ing_ports-1:0] ing_beat,
    output logic             [num_ing_ports-1:0] ing_ready,
    input  var route_table_t                     route_table,
    output logic             [num_ing_ports-1:0] out_valid,
    output tagged_beat_t     [num_ing_ports-1:0] out_beat,
    input  var logic         [num_ing_ports-1:0] out_ready,
    output logic             [num_ing_ports-1:0] drop_pulse
);

    // One route stage per ingress port
    for (genvar i = 0; i < num_ing_ports; i++) begin : g_stage
        ing_route_stage u_stage (
            .clk         (clk),
            .rst_n       (rst_n),
            .in_valid    (ing_valid[i]),
            .in_beat     (ing_beat[i]),
            .in_ready    (ing_ready[i]),
            .route_table (route_table),
            .out_valid   (out_valid[i]),
            .out_beat    (out_beat[i]),
            .out_ready   (out_ready[i]),
            .drop_pulse  (drop_pulse[i])
        );
    end

endmodule

`default_nettype wire

// File: ingress/ing_route_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ing_route_stage import p4_router_pkg::*; (
    input  var logic         clk,
    input  var logic         rst_n,
    input  var logic         in_valid,
    input  var stream_beat_t in_beat,
    output logic             in_ready,
    input  var route_table_t route_table,
    output logic             out_valid,
    output tagged_beat_t     out_beat,
    input  var logic         out_ready,
    output logic             drop_pulse
);

    logic         first;
    route_entry_t held_route;
    route_entry_t look_route;
    route_entry_t cur_route;
    logic         dropping;
    logic         accept;
    logic         fwd_beat;

    // Lookup on the destination byte, used only at the first beat
    assign look_route = route_table[dest_addr_t'(in_beat.data)];
    assign cur_route  = first ? look_route : held_route;

    // Rest of a dropped packet is swallowed without touching the output
    assign dropping   = !first && !held_route.fwd;
    assign in_ready   = dropping || !out_valid || out_ready;
    assign accept     = in_valid && in_ready;
    assign fwd_beat   = accept && cur_route.fwd;
    assign drop_pulse = accept && first && !look_route.fwd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first      <= 1'b1;
            held_route <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (accept) begin
                first <= in_beat.last;
                if (first) begin
                    held_route <= look_route;
                end
            end
            if (fwd_beat) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Output register payload
    always_ff @(posedge clk) begin
        if (fwd_beat) begin
            out_beat.beat <= in_beat;
            out_beat.egr  <= cur_route.egr;
        end
    end

endmodule

`default_nettype wire

// File: src/p4_router_regs.sv
`timescale 1ns/1ns
`default_nettype none

module p4_router_regs import p4_router_pkg::*; (
    input  var logic                     clk,
    input  var logic                     rst_n,
    input  var logic                     cfg_req,
    input  var logic                     cfg_we,
    input  var cfg_addr_t                cfg_addr,
    input  var cfg_data_t                cfg_wdata,
    output cfg_data_t                    cfg_rdata,
    output logic                         cfg_ack,
    input  var logic [num_ing_ports-1:0] drop_pulse,
    output route_table_t                 route_table
);

    typedef enum logic [1:0] {
        st_idle,
        st_ack,
        st_release
    } cfg_state_t;

    cfg_state_t state;
    drop_cnt_t  drop_cnt [num_ing_ports];
    logic       access;
    cfg_addr_t  route_off;
    cfg_addr_t  drop_off;
    logic       route_hit;
    logic       drop_hit;
    dest_addr_t route_idx;
    ing_idx_t   drop_idx;
    cfg_data_t  rdata_nxt;

    //////////////////////////////////////////////////////////////////////
    // Address decode

    assign access    = (state == st_idle) && cfg_req;
    assign route_off = cfg_addr - reg_route_base;
    assign drop_off  = cfg_addr - reg_drop_base;
    assign route_hit = route_off < cfg_addr_t'(route_entries);
    assign drop_hit  = drop_off < cfg_addr_t'(num_ing_ports);
    assign route_idx = dest_addr_t'(route_off);
    assign drop_idx  = ing_idx_t'(drop_off);

    //////////////////////////////////////////////////////////////////////
    // Four-phase slave

    assign cfg_ack = (state != st_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (cfg_req) state <= st_ack;
                st_ack:     state <= cfg_req ? st_release : st_idle;
                st_release: if (!cfg_req) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // Unmapped addresses read zero
    always_comb begin
        rdata_nxt = '0;
        if (route_hit) begin
            rdata_nxt[1:0] = route_table[route_idx];
        end else if (drop_hit) begin
            rdata_nxt = drop_cnt[drop_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            cfg_rdata <= rdata_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Route table and drop counters

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            route_table <= '0;
        end else if (access && cfg_we && route_hit) begin
            route_table[route_idx] <= route_entry_t'(cfg_wdata[1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ing_ports; i++) begin
                drop_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_ing_ports; i++) begin
                // Clear beats a drop in the same cycle
                if (access && cfg_we && drop_hit && drop_idx == ing_idx_t'(i)) begin
                    drop_cnt[i] <= '0;
                end else if (drop_pulse[i]) begin
                    drop_cnt[i] <= drop_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: common/p4_router_pkg.sv
`default_nettype none

package p4_router_pkg;

    //////////////////////////////////////////////////////////////////////
    // Port counts and sizes

    localparam int num_ing_ports = 2;
    localparam int num_egr_ports = 2;
    localparam int dest_addr_w   = 3;
    localparam int route_entries = 8;

    //////////////////////////////////////////////////////////////////////
    // Plain vector types

    typedef logic [7:0]             byte_t;
    typedef logic [dest_addr_w-1:0] dest_addr_t;
    typedef logic [0:0]             ing_idx_t;
    typedef logic [0:0]             egr_idx_t;
    // Wraps on overflow
    typedef logic [15:0]            drop_cnt_t;
    typedef logic [3:0]             cfg_addr_t;
    typedef logic [15:0]            cfg_data_t;

    //////////////////////////////////////////////////////////////////////
    // Structs

    typedef struct packed {
        byte_t data;
        logic  last;
    } stream_beat_t;

    // fwd clear means the packet is dropped
    typedef struct packed {
        logic     fwd;
        egr_idx_t egr;
    } route_entry_t;

    typedef route_entry_t [route_entries-1:0] route_table_t;

    // Beat plus the egress it is bound for
    typedef struct packed {
        stream_beat_t beat;
        egr_idx_t     egr;
    } tagged_beat_t;

    //////////////////////////////////////////////////////////////////////
    // Register map

    // Route entries, one per destination address
    localparam cfg_addr_t reg_route_base = 4'd0;
    // Drop counters, one per ingress, cleared by a write
    localparam cfg_addr_t reg_drop_base  = 4'd8;

endpackage

`default_nettype wire
